// File: hw/tia_audio_pkg.sv
/*
 * TIA audio package
 * Bus widths, audio register addresses, divider constants and the
 * waveform mode type shared by the register decode and the channel
 * engines.
 */
package tia_audio_pkg;

  // Bus and field widths
  localparam int ADDR_W = 6;  // CPU register address
  localparam int DATA_W = 8;  // CPU write data
  localparam int VOL_W  = 4;  // AUDV value and output sample
  localparam int FREQ_W = 5;  // AUDF value
  localparam int CTRL_W = 4;  // AUDC value

  // 38 * 32 * 93 = 113088 needs 17 bits
  localparam int DIV_W  = 17;

  // Audio register map, write only
  localparam logic [ADDR_W-1:0] ADDR_AUDC0 = 6'h15;  // Channel 0 control
  localparam logic [ADDR_W-1:0] ADDR_AUDC1 = 6'h16;  // Channel 1 control
  localparam logic [ADDR_W-1:0] ADDR_AUDF0 = 6'h17;  // Channel 0 frequency
  localparam logic [ADDR_W-1:0] ADDR_AUDF1 = 6'h18;  // Channel 1 frequency
  localparam logic [ADDR_W-1:0] ADDR_AUDV0 = 6'h19;  // Channel 0 volume
  localparam logic [ADDR_W-1:0] ADDR_AUDV1 = 6'h1A;  // Channel 1 volume

  // CPU ticks per step at AUDF = 0 and multiplier 1
  localparam logic [DIV_W-1:0] DIV_BASE = 17'd38;

  // Per-control multipliers on top of the base divider
  localparam logic [DIV_W-1:0] MUL_DIV15 = 17'd15;  // AUDC 2
  localparam logic [DIV_W-1:0] MUL_DIV2  = 17'd2;   // AUDC 4, 5
  localparam logic [DIV_W-1:0] MUL_DIV31 = 17'd31;  // AUDC 6, 10
  localparam logic [DIV_W-1:0] MUL_DIV6  = 17'd6;   // AUDC 12, 13, 15
  localparam logic [DIV_W-1:0] MUL_DIV93 = 17'd93;  // AUDC 14

  // Waveform source selected by AUDC
  // MODE_SILENT is zero to match the reset value of the decode
  typedef enum logic [2:0] {
    MODE_SILENT = 3'd0,  // Level forced high, output is the volume
    MODE_POLY4  = 3'd1,  // 4-bit noise
    MODE_POLY5  = 3'd2,  // 5-bit noise
    MODE_POLY9  = 3'd3,  // 9-bit noise
    MODE_TONE   = 3'd4   // Square wave
  } audio_mode_e;

endpackage

// File: hw/tia_poly_counter.sv
/*
 * TIA polynomial counter
 * Right-shifting LFSR used as a noise source. The feedback is the
 * exclusive-or of bit TAP and bit 0, fed in at the top. Starts at
 * all ones and advances one step per step_i.
 */
module tia_poly_counter #(
  parameter int WIDTH = 4,  // 4, 5 or 9 on the TIA
  parameter int TAP   = 1   // 1, 2 or 4 to match
) (
  input  logic clk,
  input  logic reset,
  input  logic step_i,
  output logic bit_o
);

  logic [WIDTH-1:0] shift_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      shift_q <= '1;  // All ones, never the lock-up state
    end else if (step_i) begin
      shift_q <= {shift_q[TAP] ^ shift_q[0], shift_q[WIDTH-1:1]};
    end
  end

  assign bit_o = shift_q[0];  // Oldest bit out

endmodule

// File: hw/tia_audio_decode.sv
/*
 * TIA audio register decode
 * Accepts CPU register writes through a valid/ready port that is only
 * ready on CPU ticks, keeps AUDC, AUDF and AUDV for both channels and
 * registers the waveform mode and divider length of each channel.
 */
module tia_audio_decode
  import tia_audio_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              cpu_tick_i,
  input  logic              wr_valid_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [DATA_W-1:0] wr_data_i,
  output logic              wr_ready_o,
  output audio_mode_e       mode0_o,
  output audio_mode_e       mode1_o,
  output logic [DIV_W-1:0]  div0_o,
  output logic [DIV_W-1:0]  div1_o,
  output logic [VOL_W-1:0]  vol0_o,
  output logic [VOL_W-1:0]  vol1_o
);

  logic              wr_en;
  logic [CTRL_W-1:0] audc0_q, audc1_q;
  logic [FREQ_W-1:0] audf0_q, audf1_q;
  logic [CTRL_W-1:0] audc0_next, audc1_next;
  logic [FREQ_W-1:0] audf0_next, audf1_next;

  // Waveform source for one AUDC value
  function automatic audio_mode_e ctrl_to_mode(input logic [CTRL_W-1:0] ctrl);
    case (ctrl)
      4'd0, 4'd11: return MODE_SILENT;
      4'd1:        return MODE_POLY4;
      4'd7, 4'd9:  return MODE_POLY5;
      4'd8:        return MODE_POLY9;
      default:     return MODE_TONE;
    endcase
  endfunction

  // Ticks per level step, minus one
  function automatic logic [DIV_W-1:0] ctrl_to_div(input logic [CTRL_W-1:0] ctrl,
                                                   input logic [FREQ_W-1:0] freq);
    logic [DIV_W-1:0] mul;
    logic [DIV_W-1:0] steps;
    case (ctrl)
      4'd2:               mul = MUL_DIV15;
      4'd4, 4'd5:         mul = MUL_DIV2;
      4'd6, 4'd10:        mul = MUL_DIV31;
      4'd12, 4'd13, 4'd15: mul = MUL_DIV6;
      4'd14:              mul = MUL_DIV93;
      default:            mul = 17'd1;
    endcase
    steps = {{(DIV_W-FREQ_W){1'b0}}, freq} + 1'b1;
    return DIV_BASE * steps * mul;  // At most 113088
  endfunction

  // Writes land only on CPU-enabled cycles
  assign wr_ready_o = cpu_tick_i;
  assign wr_en      = wr_valid_i && cpu_tick_i;

  // Register values after this cycle's write, if any
  always_comb begin
    audc0_next = audc0_q;
    audc1_next = audc1_q;
    audf0_next = audf0_q;
    audf1_next = audf1_q;
    if (wr_en) begin
      case (wr_addr_i)
        ADDR_AUDC0: audc0_next = wr_data_i[CTRL_W-1:0];
        ADDR_AUDC1: audc1_next = wr_data_i[CTRL_W-1:0];
        ADDR_AUDF0: audf0_next = wr_data_i[FREQ_W-1:0];
        ADDR_AUDF1: audf1_next = wr_data_i[FREQ_W-1:0];
        default: ;  // Volume handled below, others ignored
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      audc0_q <= '0;
      audc1_q <= '0;
      audf0_q <= '0;
      audf1_q <= '0;
      vol0_o  <= '0;
      vol1_o  <= '0;
      mode0_o <= MODE_SILENT;
      mode1_o <= MODE_SILENT;
      div0_o  <= '0;
      div1_o  <= '0;
    end else begin
      audc0_q <= audc0_next;
      audc1_q <= audc1_next;
      audf0_q <= audf0_next;
      audf1_q <= audf1_next;
      if (wr_en && wr_addr_i == ADDR_AUDV0) vol0_o <= wr_data_i[VOL_W-1:0];
      if (wr_en && wr_addr_i == ADDR_AUDV1) vol1_o <= wr_data_i[VOL_W-1:0];
      // Decoded from the merged values so they track the write edge
      mode0_o <= ctrl_to_mode(audc0_next);
      mode1_o <= ctrl_to_mode(audc1_next);
      div0_o  <= ctrl_to_div(audc0_next, audf0_next);
      div1_o  <= ctrl_to_div(audc1_next, audf1_next);
    end
  end

endmodule

// File: hw/tia_audio_channel.sv
/*
 * TIA audio channel engine
 * Divides CPU ticks by the decoded divider length, updates a one-bit
 * level from a square wave or one of three polynomial noise sources
 * and outputs the level gated by the channel volume.
 */
module tia_audio_channel
  import tia_audio_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             cpu_tick_i,
  input  audio_mode_e      mode_i,
  input  logic [DIV_W-1:0] div_i,
  input  logic [VOL_W-1:0] vol_i,
  output logic [VOL_W-1:0] sample_o
);

  logic [DIV_W-1:0] tick_cnt;
  logic             level;
  logic             next_level;
  logic             reload;
  logic             poly4_bit;
  logic             poly5_bit;
  logic             poly9_bit;

  // One reload per div_i + 1 ticks
  assign reload = cpu_tick_i && (mode_i != MODE_SILENT) && (tick_cnt >= div_i);

  // Noise sources all step together on each reload
  tia_poly_counter #(
    .WIDTH(4),
    .TAP  (1)
  ) poly4_inst (
    .clk   (clk),
    .reset (reset),
    .step_i(reload),
    .bit_o (poly4_bit)
  );

  tia_poly_counter #(
    .WIDTH(5),
    .TAP  (2)
  ) poly5_inst (
    .clk   (clk),
    .reset (reset),
    .step_i(reload),
    .bit_o (poly5_bit)
  );

  tia_poly_counter #(
    .WIDTH(9),
    .TAP  (4)
  ) poly9_inst (
    .clk   (clk),
    .reset (reset),
    .step_i(reload),
    .bit_o (poly9_bit)
  );

  always_comb begin
    case (mode_i)
      MODE_POLY4: next_level = poly4_bit;
      MODE_POLY5: next_level = poly5_bit;
      MODE_POLY9: next_level = poly9_bit;
      MODE_TONE:  next_level = ~level;  // Square wave toggle
      default:    next_level = 1'b1;
    endcase
  end

  // Tick divider and output level
  always_ff @(posedge clk) begin
    if (reset) begin
      tick_cnt <= '0;
      level    <= 1'b0;
    end else if (cpu_tick_i) begin
      if (mode_i == MODE_SILENT) begin
        tick_cnt <= '0;    // Parked while silent
        level    <= 1'b1;  // Constant volume out
      end else if (reload) begin
        tick_cnt <= '0;
        level    <= next_level;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // Volume gating
  always_ff @(posedge clk) begin
    if (reset) begin
      sample_o <= '0;
    end else begin
      sample_o <= level ? vol_i : '0;
    end
  end

endmodule

// File: hw/tia_audio.sv
/*
 * TIA audio top level
 * Register write port and audio decode feeding a left and a right
 * channel engine, each with its own divider and noise counters.
 */
module tia_audio
  import tia_audio_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              cpu_tick_i,
  input  logic              wr_valid_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [DATA_W-1:0] wr_data_i,
  output logic              wr_ready_o,
  output logic [VOL_W-1:0]  audio_left_o,
  output logic [VOL_W-1:0]  audio_right_o
);

  audio_mode_e      mode0, mode1;
  logic [DIV_W-1:0] div0, div1;
  logic [VOL_W-1:0] vol0, vol1;

  tia_audio_decode decode_inst (
    .clk       (clk),
    .reset     (reset),
    .cpu_tick_i(cpu_tick_i),
    .wr_valid_i(wr_valid_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .wr_ready_o(wr_ready_o),
    .mode0_o   (mode0),
    .mode1_o   (mode1),
    .div0_o    (div0),
    .div1_o    (div1),
    .vol0_o    (vol0),
    .vol1_o    (vol1)
  );

  // Channel 0 drives the left output
  tia_audio_channel left_inst (
    .clk       (clk),
    .reset     (reset),
    .cpu_tick_i(cpu_tick_i),
    .mode_i    (mode0),
    .div_i     (div0),
    .vol_i     (vol0),
    .sample_o  (audio_left_o)
  );

  // Channel 1 drives the right output
  tia_audio_channel right_inst (
    .clk       (clk),
    .reset     (reset),
    .cpu_tick_i(cpu_tick_i),
    .mode_i    (mode1),
    .div_i     (div1),
    .vol_i     (vol1),
    .sample_o  (audio_right_o)
  );

endmodule

// File: dv/tia_audio_tb.sv
/*
 * TIA audio testbench
 * Drives register writes and CPU ticks into the audio top level and
 * checks silence, tone periods, noise sequences and write back-pressure
 * against reference models of the decode rules and the noise counters.
 */
module tia_audio_tb
  import tia_audio_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int WRITE_LIMIT  = 64;      // Cycles a write or settle may take
  localparam int CHANGE_LIMIT = 240000;  // Over twice the longest divider
  localparam int NOISE_STEPS  = 12;
  // Several reloads at the shortest divider
  localparam int HOLD_CYCLES  = 4 * (int'(DIV_BASE) + 1);

  logic              clk;
  logic              reset;
  logic              cpu_tick;
  logic              wr_valid;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic              wr_ready;
  logic [VOL_W-1:0]  audio_left;
  logic [VOL_W-1:0]  audio_right;

  int          errors = 0;
  int          checks = 0;
  int          tests  = 0;
  int          last_stalls;
  logic [31:0] rng_state;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  tia_audio tia_audio_inst (
    .clk          (clk),
    .reset        (reset),
    .cpu_tick_i   (cpu_tick),
    .wr_valid_i   (wr_valid),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .wr_ready_o   (wr_ready),
    .audio_left_o (audio_left),
    .audio_right_o(audio_right)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Expected waveform mode and divider length for one AUDC/AUDF pair
  function automatic void ref_decode(input int audc, input int audf,
                                     output audio_mode_e mode, output int div);
    int mul;
    case (audc)
      0, 11:   mode = MODE_SILENT;
      1:       mode = MODE_POLY4;
      7, 9:    mode = MODE_POLY5;
      8:       mode = MODE_POLY9;
      default: mode = MODE_TONE;
    endcase
    case (audc)
      2:          mul = 15;
      4, 5:       mul = 2;
      6, 10:      mul = 31;
      12, 13, 15: mul = 6;
      14:         mul = 93;
      default:    mul = 1;
    endcase
    div = int'(DIV_BASE) * (audf + 1) * mul;
  endfunction

  // One step of a right-shifting noise counter of the given width
  function automatic logic [8:0] poly_step(input logic [8:0] state, input int width,
                                           input int tap);
    logic       fb;
    logic [8:0] next;
    fb = state[tap] ^ state[0];
    next = state >> 1;
    next[width-1] = fb;
    return next;
  endfunction

  task automatic check_val(input string name, input int expected, input int actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset    <= 1'b1;
    cpu_tick <= 1'b1;
    wr_valid <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  endtask

  // Returns on the rising edge that accepts the write
  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    int stalls;
    bit accepted;
    @(posedge clk);
    wr_valid <= 1'b1;
    wr_addr  <= addr;
    wr_data  <= data;
    stalls   = 0;
    accepted = 1'b0;
    while (!accepted && stalls < WRITE_LIMIT) begin
      @(negedge clk);
      if (wr_ready) begin
        accepted = 1'b1;
      end else begin
        stalls++;
      end
      @(posedge clk);
    end
    wr_valid <= 1'b0;
    last_stalls = stalls;
    if (!accepted) begin
      errors++;
      $display("timeout: write to address 0x%0h was never accepted", addr);
    end
  endtask

  // Waits for an output to reach a value, then checks that it holds
  task automatic settle_and_hold(input bit use_right, input int value);
    string            name;
    int               waited;
    logic [VOL_W-1:0] now;
    name = use_right ? "audio_right_o" : "audio_left_o";
    waited = 0;
    do begin
      @(negedge clk);
      now = use_right ? audio_right : audio_left;
      waited++;
    end while (now != value && waited < WRITE_LIMIT);
    if (now != value) begin
      errors++;
      $display("timeout: %s never settled to 0x%0h", name, value);
    end
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_val(name, value, use_right ? audio_right : audio_left);
    end
  endtask

  // Counts cycles until the output differs from its current value
  task automatic measure_change(input bit use_right, output int cycles);
    logic [VOL_W-1:0] prev;
    logic [VOL_W-1:0] now;
    bit               changed;
    prev = use_right ? audio_right : audio_left;
    cycles = 0;
    changed = 1'b0;
    while (!changed && cycles < CHANGE_LIMIT) begin
      @(negedge clk);
      cycles++;
      now = use_right ? audio_right : audio_left;
      changed = (now != prev);
    end
    if (!changed) begin
      errors++;
      $display("timeout: audio output %0d stopped changing", use_right);
    end
  endtask

  task automatic check_noise(input int ctrl);
    audio_mode_e mode;
    int          div;
    int          f;
    int          vol;
    int          width;
    int          tap;
    logic [8:0]  state;
    f   = next_rand() % 32;
    vol = 1 + next_rand() % 15;
    ref_decode(ctrl, f, mode, div);
    width = (mode == MODE_POLY4) ? 4 : (mode == MODE_POLY5) ? 5 : 9;
    tap   = (width == 4) ? 1 : (width == 5) ? 2 : 4;
    state = (9'h1 << width) - 9'h1;  // Counters start at all ones
    apply_reset();
    write_reg(ADDR_AUDV0, vol[7:0]);
    write_reg(ADDR_AUDF0, f[7:0]);
    write_reg(ADDR_AUDC0, ctrl[7:0]);
    // Middle of the level that follows the first reload
    repeat (3 + div + (div + 1) / 2) @(negedge clk);
    for (int k = 0; k < NOISE_STEPS; k++) begin
      check_val("audio_left_o", state[0] ? vol : 0, audio_left);
      state = poly_step(state, width, tap);
      if (k < NOISE_STEPS - 1) begin
        repeat (div + 1) @(negedge clk);
      end
    end
  endtask

  // Ready is a plain copy of the CPU tick
  always @(negedge clk) begin
    if (!reset) begin
      check_val("wr_ready_o", cpu_tick, wr_ready);
    end
  end

  initial begin
    int          err_start;
    int          v1;
    int          v2;
    int          rv;
    int          f;
    int          div;
    int          interval;
    int          gap;
    int          old_vol;
    int          new_vol;
    audio_mode_e mode;
    rng_state = 32'h977c_112f;
    reset     = 1'b1;
    cpu_tick  = 1'b1;
    wr_valid  = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    apply_reset();

    err_start = errors;
    @(negedge clk);
    check_val("audio_left_o", 0, audio_left);
    check_val("audio_right_o", 0, audio_right);
    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      cpu_tick <= i[0];
      @(negedge clk);
      check_val("wr_ready_o", i[0], wr_ready);
    end
    @(posedge clk);
    cpu_tick <= 1'b1;
    report_test("reset and ready", err_start);

    err_start = errors;
    v1 = 1 + next_rand() % 15;
    v2 = (v1 % 15) + 1;  // Always differs from v1
    write_reg(ADDR_AUDC0, 8'd0);
    write_reg(ADDR_AUDV0, v1[7:0]);
    settle_and_hold(1'b0, v1);
    write_reg(ADDR_AUDC0, 8'd11);
    write_reg(ADDR_AUDV0, v2[7:0]);
    settle_and_hold(1'b0, v2);
    report_test("silent", err_start);

    err_start = errors;
    f  = next_rand() % 32;
    rv = 1 + next_rand() % 15;
    ref_decode(4, f, mode, div);
    write_reg(ADDR_AUDV1, rv[7:0]);
    write_reg(ADDR_AUDF1, f[7:0]);
    write_reg(ADDR_AUDC1, 8'd4);
    repeat (3) @(negedge clk);
    measure_change(1'b1, interval);  // Phase alignment only
    for (int i = 0; i < 2; i++) begin
      measure_change(1'b1, interval);
      check_val("audio_right_o period", div + 1, interval);
      check_val("audio_left_o", v2, audio_left);
    end
    report_test("tone", err_start);

    err_start = errors;
    check_noise(1);
    check_noise(7);
    check_noise(8);
    report_test("noise", err_start);

    err_start = errors;
    old_vol = 1 + next_rand() % 15;
    new_vol = (old_vol % 15) + 1;
    rv      = 1 + next_rand() % 15;
    gap     = 2 + next_rand() % 6;
    write_reg(ADDR_AUDC0, 8'd0);
    write_reg(ADDR_AUDC1, 8'd11);
    write_reg(ADDR_AUDV0, old_vol[7:0]);
    write_reg(ADDR_AUDV1, rv[7:0]);
    settle_and_hold(1'b0, old_vol);
    settle_and_hold(1'b1, rv);
    fork
      write_reg(ADDR_AUDV0, new_vol[7:0]);
      begin
        @(posedge clk);
        cpu_tick <= 1'b0;  // Tick gap while the write is pending
        repeat (gap) @(posedge clk);
        cpu_tick <= 1'b1;
      end
      repeat (gap) begin
        @(negedge clk);
        check_val("audio_left_o", old_vol, audio_left);
      end
    join
    check_val("write stall cycles", gap, last_stalls);
    @(negedge clk);
    check_val("audio_left_o", old_vol, audio_left);
    @(negedge clk);
    check_val("audio_left_o", new_vol, audio_left);
    write_reg(6'h00, 8'(next_rand()));
    write_reg(6'h14, 8'(next_rand()));
    write_reg(6'h1B, 8'(next_rand()));
    write_reg(6'h3F, 8'(next_rand()));
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_val("audio_left_o", new_vol, audio_left);
      check_val("audio_right_o", rv, audio_right);
    end
    report_test("back-pressure", err_start);

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: compile.f
hw/tia_audio_pkg.sv
hw/tia_poly_counter.sv
hw/tia_audio_decode.sv
hw/tia_audio_channel.sv
hw/tia_audio.sv
dv/tia_audio_tb.sv

// File: Bender.yml
package:
  name: tia_audio

sources:
  - files:
      - hw/tia_audio_pkg.sv
      - hw/tia_poly_counter.sv
      - hw/tia_audio_decode.sv
      - hw/tia_audio_channel.sv
      - hw/tia_audio.sv
  - target: test
    files:
      - dv/tia_audio_tb.sv
